//--- tb.f
+incdir+logic
+incdir+test
logic/mips_pkg.sv
logic/alu.sv
logic/reg_file.sv
logic/controller.sv
logic/datapath.sv
logic/mips_cpu_harvard.sv
test/mips_cpu_tb.sv

//--- run.sh
#!/usr/bin/env bash
# builds the testbench with verilator and runs it
# the exit status of the simulation binary is the result
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f tb.f \
  --top-module mips_cpu_tb \
  -Mdir obj_dir \
  -o mips_cpu_sim

./obj_dir/mips_cpu_sim

//--- test/mips_ref_model.svh
`ifndef MIPS_REF_MODEL_SVH
`define MIPS_REF_MODEL_SVH

`include "mips_defs.svh"

// architectural state of the model
logic [`MIPS_XLEN-1:0] m_pc;
logic [`MIPS_XLEN-1:0] m_regs [`MIPS_NREG];
logic [`MIPS_XLEN-1:0] m_mem [256];  // shadow of the data ram
logic                  m_active;     // expected active after the last edge
logic                  m_halted;
logic [15:0]           lfsr_q;

// fibonacci lfsr, taps 16 14 13 11
function automatic logic lfsr_bit();
  logic fb;
  fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
  lfsr_q = {lfsr_q[14:0], fb};
  return fb;
endfunction

// one lfsr step per bit
function automatic logic [31:0] take_bits(int n);
  logic [31:0] v;
  v = 32'h0;
  for (int i = 0; i < n; i++) begin
    v = {v[30:0], lfsr_bit()};
  end
  return v;
endfunction

// isa semantics of each operation
function automatic logic [31:0] alu_ref(alu_op_t k, logic [31:0] a, logic [31:0] b,
                                        logic [4:0] sh);
  case (k)
    alu_add:  return a + b;
    alu_sub:  return a - b;
    alu_and:  return a & b;
    alu_or:   return a | b;
    alu_xor:  return a ^ b;
    alu_slt:  return {31'd0, $signed(a) < $signed(b)};
    alu_sltu: return {31'd0, a < b};
    alu_sll:  return b << sh;
    alu_srl:  return b >> sh;
    alu_lui:  return {b[15:0], 16'h0000};
    default:  return 32'h0;
  endcase
endfunction

// base plus sign extended offset
function automatic logic [31:0] ref_ea(logic [31:0] ins);
  return m_regs[ins[25:21]] + {{16{ins[15]}}, ins[15:0]};
endfunction

// retires the instruction at m_pc
function automatic void ref_step();
  logic [31:0] ins;
  logic [31:0] rs_v;
  logic [31:0] rt_v;
  logic [31:0] sx;
  logic [31:0] zx;
  logic [31:0] ea;
  logic [31:0] pc4;
  logic [31:0] word;
  logic [31:0] wval;
  logic [7:0]  byte_v;
  logic [4:0]  wreg;
  logic        wen;
  opcode_t     op;
  funct_t      fn;
  alu_op_t     k;
  load_kind_t  lk;
  pc_sel_t     ps;
  ins  = rom_fetch(m_pc);
  op   = opcode_t'(ins[31:26]);
  fn   = funct_t'(ins[5:0]);
  rs_v = m_regs[ins[25:21]];
  rt_v = m_regs[ins[20:16]];
  sx   = {{16{ins[15]}}, ins[15:0]};
  zx   = {16'h0000, ins[15:0]};
  ea   = rs_v + sx;
  pc4  = m_pc + 32'd4;
  wen  = 1'b0;
  wreg = ins[20:16]; // rt unless changed below
  wval = 32'h0;
  k    = alu_add;
  ps   = pc_seq;
  case (op)
    op_special: begin
      wreg = ins[15:11];
      case (fn)
        fn_subu: k = alu_sub;
        fn_and:  k = alu_and;
        fn_or:   k = alu_or;
        fn_xor:  k = alu_xor;
        fn_slt:  k = alu_slt;
        fn_sltu: k = alu_sltu;
        fn_sll:  k = alu_sll;
        fn_srl:  k = alu_srl;
        fn_jr:   ps = pc_jump_reg;
        default: k = alu_add;
      endcase
      wen  = (fn != fn_jr);
      wval = alu_ref(k, rs_v, rt_v, ins[10:6]);
    end
    op_addiu: begin
      wen  = 1'b1;
      wval = alu_ref(alu_add, rs_v, sx, 5'd0);
    end
    op_slti: begin
      wen  = 1'b1;
      wval = alu_ref(alu_slt, rs_v, sx, 5'd0);
    end
    op_andi, op_ori, op_xori: begin
      wen  = 1'b1;
      k    = (op == op_andi) ? alu_and : (op == op_ori) ? alu_or : alu_xor;
      wval = alu_ref(k, rs_v, zx, 5'd0); // logical ops zero extend
    end
    op_lui: begin
      wen  = 1'b1;
      wval = alu_ref(alu_lui, 32'h0, zx, 5'd0);
    end
    op_lw, op_lb, op_lbu: begin
      wen    = 1'b1;
      word   = m_mem[ea[9:2]];
      byte_v = 8'(word >> {~ea[1:0], 3'b000}); // big-endian, offset 0 is msb
      lk     = (op == op_lw) ? load_word : (op == op_lb) ? load_byte_signed
                                                         : load_byte_unsigned;
      case (lk)
        load_byte_signed:   wval = {{24{byte_v[7]}}, byte_v};
        load_byte_unsigned: wval = {24'h000000, byte_v};
        default:            wval = word;
      endcase
    end
    op_sw:  m_mem[ea[9:2]] = rt_v;
    op_beq: ps = (rs_v == rt_v) ? pc_branch : pc_seq;
    op_bne: ps = (rs_v != rt_v) ? pc_branch : pc_seq;
    op_j:   ps = pc_jump;
    op_jal: begin
      ps   = pc_jump;
      wen  = 1'b1;
      wreg = 5'd31; // $ra
      wval = pc4;
    end
    default: wen = 1'b0;
  endcase
  case (ps)
    pc_branch:   m_pc = pc4 + {sx[29:0], 2'b00};
    pc_jump:     m_pc = {pc4[31:28], ins[25:0], 2'b00};
    pc_jump_reg: m_pc = rs_v;
    default:     m_pc = pc4;
  endcase
  if (wen && wreg != 5'd0) m_regs[wreg] = wval; // $zero stays 0
endfunction

task automatic check_word(string name, logic [`MIPS_XLEN-1:0] got,
                          logic [`MIPS_XLEN-1:0] exp);
  if (got !== exp) begin
    abort_run($sformatf("FAIL %s got %h expected %h at %0t", name, got, exp, $time));
  end
endtask

task automatic check_flag(string name, logic got, logic exp);
  if (got !== exp) begin
    abort_run($sformatf("FAIL %s got %h expected %h at %0t", name, got, exp, $time));
  end
endtask

task automatic check_v0(logic [`MIPS_XLEN-1:0] got, logic [`MIPS_XLEN-1:0] exp);
  if (got !== exp) begin
    abort_run($sformatf("FAIL register_v0 got %h expected %h at %0t", got, exp, $time));
  end
endtask

`endif

//--- test/mips_cpu_tb.sv
`timescale 1ns/1ps
`include "mips_defs.svh"

module mips_cpu_tb;
  import mips_pkg::*;

  localparam int n_random = 120; // random block ahead of the fixed loop

  logic                  clk;
  logic                  reset;
  logic                  clk_enable;
  logic                  active;
  logic [`MIPS_XLEN-1:0] register_v0;
  logic [`MIPS_XLEN-1:0] instr_address;
  logic [`MIPS_XLEN-1:0] instr_readdata;
  logic [`MIPS_XLEN-1:0] data_address;
  logic                  data_write;
  logic                  data_read;
  logic [`MIPS_XLEN-1:0] data_writedata;
  logic [`MIPS_XLEN-1:0] data_readdata;

  logic [`MIPS_XLEN-1:0] rom [256]; // word 0 at the reset vector
  logic [`MIPS_XLEN-1:0] ram [256];
  int                    emit_idx;
  int                    prog_len;  // 0 until the program is built
  int                    retired;

  task automatic abort_run(string why);
    $display("%s", why);
    $display("tests failed");
    $fatal(1, "simulation stopped on error");
  endtask

  // nop outside the program image so address 0 fetches sll $0
  function automatic logic [`MIPS_XLEN-1:0] rom_fetch(logic [`MIPS_XLEN-1:0] addr);
    logic [31:0] off;
    off = addr - `MIPS_RESET_VECTOR;
    if (off < 32'd1024) return rom[off[9:2]];
    return 32'h0;
  endfunction

  `include "mips_ref_model.svh"

  mips_cpu_harvard mips_cpu_harvard_i (
    .clk            (clk),
    .reset          (reset),
    .active         (active),
    .register_v0    (register_v0),
    .clk_enable     (clk_enable),
    .instr_address  (instr_address),
    .instr_readdata (instr_readdata),
    .data_address   (data_address),
    .data_write     (data_write),
    .data_read      (data_read),
    .data_writedata (data_writedata),
    .data_readdata  (data_readdata)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk; // 100 ns period

  // both memories answer in the same cycle
  assign instr_readdata = rom_fetch(instr_address);
  assign data_readdata  = ram[data_address[9:2]];

  always @(posedge clk) begin
    if (data_write) ram[data_address[9:2]] <= data_writedata; // store at end of cycle
  end

  function automatic logic [31:0] enc_r(funct_t fn, logic [4:0] rs, logic [4:0] rt,
                                        logic [4:0] rd, logic [4:0] sh);
    return {op_special, rs, rt, rd, sh, fn};
  endfunction

  function automatic logic [31:0] enc_i(opcode_t op, logic [4:0] rs, logic [4:0] rt,
                                        logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  // j and jal to rom word idx
  function automatic logic [31:0] enc_j(opcode_t op, int idx);
    logic [31:0] a;
    a = `MIPS_RESET_VECTOR + 32'(idx * 4);
    return {op, a[27:2]};
  endfunction

  // registers 0..7 only so $v0 gets hit often
  function automatic logic [4:0] pick_reg();
    logic [31:0] r;
    r = take_bits(3);
    return r[4:0];
  endfunction

  // low about 1 cycle in 8
  function automatic logic pick_enable();
    logic [31:0] r;
    r = take_bits(3);
    return (r[2:0] != 3'd0);
  endfunction

  function automatic logic [31:0] rand_instr();
    logic [31:0] k;
    logic [31:0] sel;
    logic [31:0] imm;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    k   = take_bits(2);  // half r-type, quarter immediate, quarter memory
    sel = take_bits(4);
    imm = take_bits(16);
    rs  = pick_reg();
    rt  = pick_reg();
    rd  = pick_reg();
    if (k < 2) begin
      case (sel % 9)
        0:       return enc_r(fn_addu, rs, rt, rd, 5'd0);
        1:       return enc_r(fn_subu, rs, rt, rd, 5'd0);
        2:       return enc_r(fn_and, rs, rt, rd, 5'd0);
        3:       return enc_r(fn_or, rs, rt, rd, 5'd0);
        4:       return enc_r(fn_xor, rs, rt, rd, 5'd0);
        5:       return enc_r(fn_slt, rs, rt, rd, 5'd0);
        6:       return enc_r(fn_sltu, rs, rt, rd, 5'd0);
        7:       return enc_r(fn_sll, 5'd0, rt, rd, imm[4:0]);
        default: return enc_r(fn_srl, 5'd0, rt, rd, imm[4:0]);
      endcase
    end else if (k == 2) begin
      case (sel % 6)
        0:       return enc_i(op_addiu, rs, rt, imm[15:0]);
        1:       return enc_i(op_slti, rs, rt, imm[15:0]);
        2:       return enc_i(op_andi, rs, rt, imm[15:0]);
        3:       return enc_i(op_ori, rs, rt, imm[15:0]);
        4:       return enc_i(op_xori, rs, rt, imm[15:0]);
        default: return enc_i(op_lui, 5'd0, rt, imm[15:0]);
      endcase
    end
    // base $zero, word offsets for lw/sw, any byte lane for lb/lbu
    case (sel[1:0])
      2'd0:    return enc_i(op_lw, 5'd0, rt, {6'd0, imm[7:0], 2'b00});
      2'd1:    return enc_i(op_lb, 5'd0, rt, {6'd0, imm[9:0]});
      2'd2:    return enc_i(op_lbu, 5'd0, rt, {6'd0, imm[9:0]});
      default: return enc_i(op_sw, 5'd0, rt, {6'd0, imm[7:0], 2'b00});
    endcase
  endfunction

  task automatic emit(logic [31:0] w);
    rom[emit_idx] = w;
    emit_idx++;
  endtask

  // lockstep compare while outputs still hold the pre-edge values
  always @(posedge clk) begin
    logic [31:0] ins;
    opcode_t     op;
    if (!reset) begin
      ins = rom_fetch(m_pc);
      op  = opcode_t'(ins[31:26]);
      check_word("instr_address", instr_address, m_pc);
      check_flag("active", active, m_active);
      check_v0(register_v0, m_regs[`MIPS_REG_V0]);
      check_flag("data_read", data_read, op inside {op_lw, op_lb, op_lbu});
      check_flag("data_write", data_write, clk_enable && op == op_sw);
      if (data_write) begin
        check_word("data_address", data_address, ref_ea(ins));
        check_word("data_writedata", data_writedata, m_regs[ins[20:16]]);
      end
      if (clk_enable) begin
        ref_step();
        retired++;
        if (m_pc == 32'h0) m_halted = 1'b1;
      end
      m_active = clk_enable && !m_halted; // stalled edges read inactive
    end
  end

  // watchdog allows four clock periods per program word
  initial begin
    wait (prog_len > 0);
    #(4 * prog_len * 100);
    abort_run("watchdog timeout, the core never jumped to address 0");
  end

  initial begin
    reset      = 1'b1;
    clk_enable = 1'b1;
    lfsr_q     = 16'd57362;
    m_pc       = `MIPS_RESET_VECTOR;
    m_active   = 1'b1;
    m_halted   = 1'b0;
    retired    = 0;
    prog_len   = 0;
    emit_idx   = 0;
    for (int i = 0; i < `MIPS_NREG; i++) m_regs[i] = 32'h0;
    for (int i = 0; i < 256; i++) begin
      ram[i]   = take_bits(32);
      m_mem[i] = ram[i];
      rom[i]   = 32'h0;
    end
    for (int i = 0; i < n_random; i++) emit(rand_instr());
    // fixed control flow block from word n_random onward
    emit(enc_i(op_addiu, 5'd0, 5'd8, 16'd3));       // +0  loop count
    emit(enc_i(op_addiu, 5'd0, 5'd9, 16'd5));       // +1
    emit(enc_i(op_addiu, 5'd2, 5'd2, 16'd7));       // +2  loop body moves $v0
    emit(enc_i(op_addiu, 5'd8, 5'd8, 16'hFFFF));    // +3
    emit(enc_i(op_bne, 5'd8, 5'd0, 16'hFFFD));      // +4  back to +2 and taken twice
    emit(enc_i(op_beq, 5'd8, 5'd0, 16'd1));         // +5  taken and skips +6
    emit(enc_i(op_addiu, 5'd0, 5'd2, 16'd1));       // +6
    emit(enc_i(op_beq, 5'd9, 5'd0, 16'd1));         // +7  not taken
    emit(enc_j(op_jal, n_random + 11));             // +8
    emit(enc_j(op_j, n_random + 13));               // +9  after return
    emit(enc_i(op_addiu, 5'd0, 5'd2, 16'h0055));    // +10 jumped over
    emit(enc_i(op_xori, 5'd2, 5'd2, 16'h1234));     // +11 subroutine
    emit(enc_r(fn_jr, 5'd31, 5'd0, 5'd0, 5'd0));    // +12
    emit(enc_r(fn_jr, 5'd0, 5'd0, 5'd0, 5'd0));     // +13 halt through $zero
    prog_len = emit_idx;

    repeat (10) @(posedge clk);
    @(negedge clk);
    // still in reset
    check_word("instr_address", instr_address, `MIPS_RESET_VECTOR);
    check_flag("active", active, 1'b1);
    check_flag("data_write", data_write, 1'b0);
    check_flag("data_read", data_read, 1'b0);
    reset      = 1'b0;
    clk_enable = pick_enable();
    @(negedge clk);
    while (!m_halted) begin
      clk_enable = pick_enable();
      @(negedge clk);
    end

    // core sits at address 0 now
    clk_enable = 1'b0;
    check_word("instr_address", instr_address, 32'h0);
    check_flag("active", active, 1'b0);
    @(posedge clk);
    @(negedge clk);
    check_word("instr_address", instr_address, 32'h0);
    $display("retired %0d instructions", retired);
    $display("all tests passed");
    $finish;
  end

endmodule

//--- logic/mips_cpu_harvard.sv
`timescale 1ns/1ps
`include "mips_defs.svh"

module mips_cpu_harvard (
  input  logic                  clk,
  input  logic                  reset,
  output logic                  active,
  output logic [`MIPS_XLEN-1:0] register_v0,
  input  logic                  clk_enable,
  output logic [`MIPS_XLEN-1:0] instr_address,
  input  logic [`MIPS_XLEN-1:0] instr_readdata,
  output logic [`MIPS_XLEN-1:0] data_address,
  output logic                  data_write,
  output logic                  data_read,
  output logic [`MIPS_XLEN-1:0] data_writedata,
  input  logic [`MIPS_XLEN-1:0] data_readdata
);
  import mips_pkg::*;

  logic       reg_write, reg_dst_rd, link, mem_to_reg;
  logic       mem_read, mem_write, alu_src_imm, imm_zero_ext, zero;
  alu_op_t    alu_op;
  load_kind_t load_kind;
  pc_sel_t    pc_sel;
  logic       halt_now; // this cycle sends the pc to 0
  logic       halted;   // sticky once pc reached 0

  controller controller_i (
    .op           (opcode_t'(instr_readdata[31:26])),
    .funct        (funct_t'(instr_readdata[5:0])),
    .rt           (instr_readdata[20:16]),
    .zero         (zero),
    .reg_write    (reg_write),
    .reg_dst_rd   (reg_dst_rd),
    .link         (link),
    .mem_to_reg   (mem_to_reg),
    .mem_read     (mem_read),
    .mem_write    (mem_write),
    .alu_src_imm  (alu_src_imm),
    .imm_zero_ext (imm_zero_ext),
    .alu_op       (alu_op),
    .load_kind    (load_kind),
    .pc_sel       (pc_sel)
  );

  datapath datapath_i (
    .clk            (clk),
    .reset          (reset),
    .enable         (clk_enable),
    .reg_write      (reg_write & clk_enable), // stall blocks the write
    .reg_dst_rd     (reg_dst_rd),
    .link           (link),
    .mem_to_reg     (mem_to_reg),
    .alu_src_imm    (alu_src_imm),
    .imm_zero_ext   (imm_zero_ext),
    .alu_op         (alu_op),
    .load_kind      (load_kind),
    .pc_sel         (pc_sel),
    .zero           (zero),
    .instr_address  (instr_address),
    .instr          (instr_readdata),
    .data_readdata  (data_readdata),
    .data_address   (data_address),
    .data_writedata (data_writedata),
    .register_v0    (register_v0)
  );

  // memory strobes quiet in reset, stores only on enabled cycles
  assign data_write = mem_write & clk_enable & ~reset;
  assign data_read  = mem_read & ~reset;

  // jr puts rs on the alu output, so a zero target shows on data_address
  assign halt_now = (pc_sel == pc_jump_reg) && (data_address == '0);

  always_ff @(posedge clk) begin
    if (reset) begin
      halted <= 1'b0;
      active <= 1'b1;
    end else begin
      if (clk_enable && halt_now) halted <= 1'b1;
      // stalled cycles read as inactive
      active <= clk_enable && !halted && !halt_now;
    end
  end

  a_v0_stall: assert property (@(posedge clk) disable iff (reset)
                               !clk_enable |=> $stable(register_v0))
    else $error("mips_cpu_harvard: register write during stall");

endmodule

//--- logic/datapath.sv
`timescale 1ns/1ps
`include "mips_defs.svh"

module datapath (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  enable,
  input  logic                  reg_write,
  input  logic                  reg_dst_rd,
  input  logic                  link,
  input  logic                  mem_to_reg,
  input  logic                  alu_src_imm,
  input  logic                  imm_zero_ext,
  input  mips_pkg::alu_op_t     alu_op,
  input  mips_pkg::load_kind_t  load_kind,
  input  mips_pkg::pc_sel_t     pc_sel,
  output logic                  zero,
  output logic [`MIPS_XLEN-1:0] instr_address,
  input  logic [`MIPS_XLEN-1:0] instr,
  input  logic [`MIPS_XLEN-1:0] data_readdata,
  output logic [`MIPS_XLEN-1:0] data_address,
  output logic [`MIPS_XLEN-1:0] data_writedata,
  output logic [`MIPS_XLEN-1:0] register_v0
);
  import mips_pkg::*;

  localparam int aw = $clog2(`MIPS_NREG);
  localparam logic [aw-1:0] link_idx = aw'(`MIPS_NREG - 1); // $ra

  logic [`MIPS_XLEN-1:0] pc;
  logic [`MIPS_XLEN-1:0] pc_plus4;
  logic [`MIPS_XLEN-1:0] next_pc;
  logic [aw-1:0]         rs;
  logic [aw-1:0]         rt;
  logic [aw-1:0]         rd;
  logic [4:0]            shamt;
  logic [15:0]           imm;
  logic [25:0]           target;
  logic [`MIPS_XLEN-1:0] imm_ext;
  logic [aw-1:0]         wa;
  logic [`MIPS_XLEN-1:0] wd;
  logic [`MIPS_XLEN-1:0] rs_val;
  logic [`MIPS_XLEN-1:0] rt_val;
  logic [`MIPS_XLEN-1:0] alu_b;
  logic [`MIPS_XLEN-1:0] alu_result;
  logic [7:0]            load_byte;
  logic [`MIPS_XLEN-1:0] load_value;

  // instruction fields
  assign rs     = instr[25:21];
  assign rt     = instr[20:16];
  assign rd     = instr[15:11];
  assign shamt  = instr[10:6];
  assign imm    = instr[15:0];
  assign target = instr[25:0];

  assign imm_ext = imm_zero_ext ? {{(`MIPS_XLEN-16){1'b0}}, imm}
                                : {{(`MIPS_XLEN-16){imm[15]}}, imm};

  always_ff @(posedge clk) begin
    if (reset) pc <= `MIPS_RESET_VECTOR;
    else if (enable) pc <= next_pc; // hold while stalled
  end

  assign instr_address = pc;
  assign pc_plus4      = pc + 32'd4;

  // no delay slot so a redirect takes effect next cycle
  always_comb begin
    case (pc_sel)
      pc_branch:   next_pc = pc_plus4 + {imm_ext[`MIPS_XLEN-3:0], 2'b00};
      pc_jump:     next_pc = {pc_plus4[31:28], target, 2'b00};
      pc_jump_reg: next_pc = rs_val;
      default:     next_pc = pc_plus4;
    endcase
  end

  // destination is $ra for jal and otherwise rd or rt
  assign wa = link ? link_idx : (reg_dst_rd ? rd : rt);

  reg_file reg_file_i (
    .clk   (clk),
    .reset (reset),
    .we    (reg_write),
    .ra1   (rs),
    .ra2   (rt),
    .wa    (wa),
    .wd    (wd),
    .rd1   (rs_val),
    .rd2   (rt_val),
    .v0    (register_v0)
  );

  assign alu_b = alu_src_imm ? imm_ext : rt_val;

  alu alu_i (
    .op     (alu_op),
    .a      (rs_val),
    .b      (alu_b),
    .shamt  (shamt),
    .result (alu_result),
    .zero   (zero)
  );

  assign data_address   = alu_result; // effective address
  assign data_writedata = rt_val;     // sw source

  // big-endian byte lanes with offset 0 as the top byte
  always_comb begin
    case (data_address[1:0])
      2'd0:    load_byte = data_readdata[31:24];
      2'd1:    load_byte = data_readdata[23:16];
      2'd2:    load_byte = data_readdata[15:8];
      default: load_byte = data_readdata[7:0];
    endcase
    case (load_kind)
      load_byte_signed:   load_value = {{(`MIPS_XLEN-8){load_byte[7]}}, load_byte};
      load_byte_unsigned: load_value = {{(`MIPS_XLEN-8){1'b0}}, load_byte};
      default:            load_value = data_readdata; // lw
    endcase
  end

  // write-back select
  assign wd = link ? pc_plus4 : (mem_to_reg ? load_value : alu_result);

endmodule

//--- logic/controller.sv
`timescale 1ns/1ps

module controller (
  input  mips_pkg::opcode_t    op,
  input  mips_pkg::funct_t     funct,
  input  logic [4:0]           rt,
  input  logic                 zero,
  output logic                 reg_write,
  output logic                 reg_dst_rd,
  output logic                 link,
  output logic                 mem_to_reg,
  output logic                 mem_read,
  output logic                 mem_write,
  output logic                 alu_src_imm,
  output logic                 imm_zero_ext,
  output mips_pkg::alu_op_t    alu_op,
  output mips_pkg::load_kind_t load_kind,
  output mips_pkg::pc_sel_t    pc_sel
);
  import mips_pkg::*;

  pc_sel_t pc_sel_dec; // before branch resolution
  logic    branch_ne;  // bne sense, taken on !zero
  logic    rt_live;    // i-type target is not $zero
  logic    take;

  assign rt_live = (rt != 5'd0);

  always_comb begin
    // defaults decode to a no-op
    reg_write    = 1'b0;
    reg_dst_rd   = 1'b0;
    link         = 1'b0;
    mem_to_reg   = 1'b0;
    mem_read     = 1'b0;
    mem_write    = 1'b0;
    alu_src_imm  = 1'b0;
    imm_zero_ext = 1'b0;
    alu_op       = alu_add;
    load_kind    = load_word;
    pc_sel_dec   = pc_seq;
    branch_ne    = 1'b0;
    case (op)
      op_special: begin
        reg_dst_rd = 1'b1; // rd is the target
        reg_write  = 1'b1;
        case (funct)
          fn_sll:  alu_op = alu_sll;
          fn_srl:  alu_op = alu_srl;
          fn_addu: alu_op = alu_add;
          fn_subu: alu_op = alu_sub;
          fn_and:  alu_op = alu_and;
          fn_or:   alu_op = alu_or;
          fn_xor:  alu_op = alu_xor;
          fn_slt:  alu_op = alu_slt;
          fn_sltu: alu_op = alu_sltu;
          fn_jr: begin
            reg_write  = 1'b0;
            pc_sel_dec = pc_jump_reg;
            alu_op     = alu_add; // rs + $zero shows the target on the alu
          end
          default: reg_write = 1'b0; // unknown funct, nop
        endcase
      end
      op_j: pc_sel_dec = pc_jump;
      op_jal: begin
        pc_sel_dec = pc_jump;
        link       = 1'b1; // $ra gets pc+4
        reg_write  = 1'b1;
      end
      op_beq: begin
        alu_op     = alu_sub; // zero flags equality
        pc_sel_dec = pc_branch;
      end
      op_bne: begin
        alu_op     = alu_sub;
        pc_sel_dec = pc_branch;
        branch_ne  = 1'b1;
      end
      op_addiu, op_slti, op_andi, op_ori, op_xori, op_lui: begin
        alu_src_imm = 1'b1;
        reg_write   = rt_live; // writes to $zero dropped here
        case (op)
          op_slti: alu_op = alu_slt;
          op_andi: alu_op = alu_and;
          op_ori:  alu_op = alu_or;
          op_xori: alu_op = alu_xor;
          op_lui:  alu_op = alu_lui;
          default: alu_op = alu_add;
        endcase
        // logical immediates are zero extended
        imm_zero_ext = (op == op_andi) || (op == op_ori) || (op == op_xori);
      end
      op_lw, op_lb, op_lbu: begin
        alu_src_imm = 1'b1; // base + offset
        mem_read    = 1'b1;
        mem_to_reg  = 1'b1;
        reg_write   = rt_live;
        if (op == op_lb) load_kind = load_byte_signed;
        else if (op == op_lbu) load_kind = load_byte_unsigned;
      end
      op_sw: begin
        alu_src_imm = 1'b1;
        mem_write   = 1'b1;
      end
      default: ; // unknown opcode, nop
    endcase
  end

  // branch resolution kept apart from decode
  assign take   = zero ^ branch_ne;
  assign pc_sel = (pc_sel_dec == pc_branch && !take) ? pc_seq : pc_sel_dec;

  always_comb begin
    assert (!(mem_read && mem_write))
      else $error("controller: load and store decoded together");
  end

endmodule

//--- logic/reg_file.sv
`timescale 1ns/1ps
`include "mips_defs.svh"

module reg_file (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  we,
  input  logic [4:0]            ra1,
  input  logic [4:0]            ra2,
  input  logic [4:0]            wa,
  input  logic [`MIPS_XLEN-1:0] wd,
  output logic [`MIPS_XLEN-1:0] rd1,
  output logic [`MIPS_XLEN-1:0] rd2,
  output logic [`MIPS_XLEN-1:0] v0
);

  logic [`MIPS_XLEN-1:0] regs [`MIPS_NREG];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `MIPS_NREG; i++) regs[i] <= '0;
    end else if (we && wa != 5'd0) begin // $zero never stored
      regs[wa] <= wd;
    end
  end

  // async reads, $zero forced
  assign rd1 = (ra1 == 5'd0) ? '0 : regs[ra1];
  assign rd2 = (ra2 == 5'd0) ? '0 : regs[ra2];
  assign v0  = regs[`MIPS_REG_V0];

  a_zero_storage: assert property (@(posedge clk) disable iff (reset) regs[0] == '0)
    else $error("reg_file: register 0 storage written");

endmodule

//--- logic/alu.sv
`timescale 1ns/1ps
`include "mips_defs.svh"

module alu (
  input  mips_pkg::alu_op_t      op,
  input  logic [`MIPS_XLEN-1:0] a,
  input  logic [`MIPS_XLEN-1:0] b,
  input  logic [4:0]            shamt,
  output logic [`MIPS_XLEN-1:0] result,
  output logic                  zero
);
  import mips_pkg::*;

  logic signed [`MIPS_XLEN-1:0] a_s;
  logic signed [`MIPS_XLEN-1:0] b_s;
  logic [`MIPS_XLEN-1:0]        diff;

  assign a_s  = a;
  assign b_s  = b;
  assign diff = a - b; // shared by sub and beq/bne

  always_comb begin
    case (op)
      alu_add:  result = a + b;
      alu_sub:  result = diff;
      alu_and:  result = a & b;
      alu_or:   result = a | b;
      alu_xor:  result = a ^ b;
      alu_nor:  result = ~(a | b);
      alu_slt: begin
        result = '0;
        result[0] = (a_s < b_s); // signed compare
      end
      alu_sltu: begin
        result = '0;
        result[0] = (a < b);
      end
      // shifts act on the rt operand
      alu_sll:  result = b << shamt;
      alu_srl:  result = b >> shamt; // logical, zero fill
      alu_lui:  result = b << 16;    // immediate to upper half
      default:  result = '0;
    endcase
  end

  assign zero = (result == '0);

endmodule

//--- logic/mips_pkg.sv
package mips_pkg;

  // primary opcodes, instr[31:26]
  typedef enum logic [5:0] {
    op_special = 6'h00, // r-type, decode on funct
    op_j       = 6'h02,
    op_jal     = 6'h03,
    op_beq     = 6'h04,
    op_bne     = 6'h05,
    op_addiu   = 6'h09,
    op_slti    = 6'h0a,
    op_andi    = 6'h0c,
    op_ori     = 6'h0d,
    op_xori    = 6'h0e,
    op_lui     = 6'h0f,
    op_lb      = 6'h20,
    op_lw      = 6'h23,
    op_lbu     = 6'h24,
    op_sw      = 6'h2b
  } opcode_t;

  // special functions, instr[5:0]
  typedef enum logic [5:0] {
    fn_sll  = 6'h00,
    fn_srl  = 6'h02,
    fn_jr   = 6'h08,
    fn_addu = 6'h21,
    fn_subu = 6'h23,
    fn_and  = 6'h24,
    fn_or   = 6'h25,
    fn_xor  = 6'h26,
    fn_slt  = 6'h2a,
    fn_sltu = 6'h2b
  } funct_t;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_nor,
    alu_slt, alu_sltu, alu_sll, alu_srl, alu_lui
  } alu_op_t;

  typedef enum logic [1:0] {
    load_word, load_byte_signed, load_byte_unsigned
  } load_kind_t;

  // next pc source
  typedef enum logic [1:0] {
    pc_seq, pc_branch, pc_jump, pc_jump_reg
  } pc_sel_t;

endpackage

//--- logic/mips_defs.svh
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

// data path width, one machine word
`define MIPS_XLEN 32

// architectural register count
`define MIPS_NREG 32

// first fetch after reset, kseg1 boot rom
`define MIPS_RESET_VECTOR 32'hBFC00000

// $v0, exported to the environment
`define MIPS_REG_V0 2

`endif
